// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module tb_uart_dbg -f tb.f
	@out="$$(./obj_dir/Vtb_uart_dbg)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== rtl/dbg_cmd_engine.sv ====
`timescale 1ns/1ps

`include "uart_dbg_consts.svh"

module dbg_cmd_engine (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  logic                    rx_valid_i,
  input  uart_dbg_pkg::byte_t     rx_data_i,
  input  logic                    tx_busy_i,
  output logic                    tx_start_o,
  output uart_dbg_pkg::byte_t     tx_data_o,
  output logic                    mem_we_o,
  output uart_dbg_pkg::mem_addr_t mem_addr_o,
  output uart_dbg_pkg::byte_t     mem_wdata_o,
  input  uart_dbg_pkg::byte_t     mem_rdata_i,
  output logic                    exec_o,
  output uart_dbg_pkg::entry_t    entry_o
);

  localparam int field_cnt_w = $clog2(`DBG_FIELD_BYTES);

  uart_dbg_pkg::engine_state_e state_q;
  uart_dbg_pkg::byte_t         cmd_q;
  logic [field_cnt_w-1:0]      field_cnt_q;
  logic                        field_idx_q;
  logic                        field_done;
  uart_dbg_pkg::mem_addr_t     addr_q;
  uart_dbg_pkg::dbg_len_t      remaining_q;
  logic                        rd_wait_q;
  uart_dbg_pkg::entry_t        entry_acc_q;

  assign field_done = field_cnt_q == field_cnt_w'(`DBG_FIELD_BYTES - 1);

  // Reply strobe goes out in the cycle the transmitter is free
  always_comb begin
    tx_start_o = 1'b0;
    tx_data_o  = `DBG_ACK;
    case (state_q)
      uart_dbg_pkg::SEND_ACK,
      uart_dbg_pkg::EXEC: begin
        tx_start_o = !tx_busy_i;
      end
      uart_dbg_pkg::DATA_OUT: begin
        tx_start_o = !tx_busy_i && !rd_wait_q;
        tx_data_o  = mem_rdata_i;
      end
      uart_dbg_pkg::SEND_EOT: begin
        tx_start_o = !tx_busy_i;
        tx_data_o  = `DBG_EOT;
      end
      default: begin
      end
    endcase
  end

  // Payload bytes go straight into memory
  assign mem_we_o    = (state_q == uart_dbg_pkg::DATA_IN) && rx_valid_i;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = rx_data_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= uart_dbg_pkg::IDLE;
      cmd_q       <= '0;
      field_cnt_q <= '0;
      field_idx_q <= 1'b0;
      addr_q      <= '0;
      remaining_q <= '0;
      rd_wait_q   <= 1'b0;
      exec_o      <= 1'b0;
      entry_o     <= '0;
    end else begin
      exec_o <= 1'b0;
      case (state_q)
        uart_dbg_pkg::IDLE: begin
          if (rx_valid_i) begin
            case (rx_data_i)
              `DBG_ACK: begin
                cmd_q   <= rx_data_i;
                state_q <= uart_dbg_pkg::SEND_ACK;
              end
              `DBG_CMD_READ,
              `DBG_CMD_WRITE,
              `DBG_CMD_EXEC: begin
                cmd_q       <= rx_data_i;
                field_cnt_q <= '0;
                field_idx_q <= 1'b0;
                state_q     <= uart_dbg_pkg::FIELD;
              end
              // Unknown bytes are dropped
              default: begin
              end
            endcase
          end
        end
        uart_dbg_pkg::FIELD: begin
          if (rx_valid_i) begin
            field_cnt_q <= field_cnt_q + 1'b1;
            // Only the low address byte and low two length bytes matter
            if (cmd_q != `DBG_CMD_EXEC) begin
              if (!field_idx_q && field_cnt_q == '0) begin
                addr_q <= rx_data_i;
              end
              if (field_idx_q && field_cnt_q == '0) begin
                remaining_q[7:0] <= rx_data_i;
              end
              if (field_idx_q && field_cnt_q == field_cnt_w'(1)) begin
                remaining_q[15:8] <= rx_data_i;
              end
            end
            if (field_done) begin
              if (cmd_q == `DBG_CMD_EXEC) begin
                exec_o  <= 1'b1;
                entry_o <= {rx_data_i, entry_acc_q[63:8]};
                state_q <= uart_dbg_pkg::EXEC;
              end else if (!field_idx_q) begin
                field_idx_q <= 1'b1;
              end else begin
                state_q <= uart_dbg_pkg::SEND_ACK;
              end
            end
          end
        end
        uart_dbg_pkg::SEND_ACK: begin
          if (tx_start_o) begin
            case (cmd_q)
              `DBG_CMD_WRITE: begin
                state_q <= (remaining_q == '0) ? uart_dbg_pkg::SEND_EOT
                                               : uart_dbg_pkg::DATA_IN;
              end
              `DBG_CMD_READ: begin
                rd_wait_q <= 1'b1;
                state_q   <= (remaining_q == '0) ? uart_dbg_pkg::SEND_EOT
                                                 : uart_dbg_pkg::DATA_OUT;
              end
              default: begin
                state_q <= uart_dbg_pkg::IDLE;
              end
            endcase
          end
        end
        uart_dbg_pkg::DATA_IN: begin
          if (rx_valid_i) begin
            addr_q      <= addr_q + 1'b1;
            remaining_q <= remaining_q - 1'b1;
            if (remaining_q == 16'd1) begin
              state_q <= uart_dbg_pkg::SEND_EOT;
            end
          end
        end
        uart_dbg_pkg::DATA_OUT: begin
          // One idle cycle lets the read data settle for the new address
          if (rd_wait_q) begin
            rd_wait_q <= 1'b0;
          end else if (tx_start_o) begin
            rd_wait_q   <= 1'b1;
            addr_q      <= addr_q + 1'b1;
            remaining_q <= remaining_q - 1'b1;
            if (remaining_q == 16'd1) begin
              state_q <= uart_dbg_pkg::SEND_EOT;
            end
          end
        end
        uart_dbg_pkg::SEND_EOT,
        uart_dbg_pkg::EXEC: begin
          if (tx_start_o) begin
            state_q <= uart_dbg_pkg::IDLE;
          end
        end
        default: begin
          state_q <= uart_dbg_pkg::IDLE;
        end
      endcase
    end
  end

  // Entry arrives LSB first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state_q == uart_dbg_pkg::FIELD && rx_valid_i) begin
      entry_acc_q <= {rx_data_i, entry_acc_q[63:8]};
    end
  end

endmodule

// ==== rtl/dbg_scratch_mem.sv ====
`timescale 1ns/1ps

`include "uart_dbg_consts.svh"

module dbg_scratch_mem (
  input  logic                    clk,
  input  logic                    mem_we_i,
  input  uart_dbg_pkg::mem_addr_t mem_addr_i,
  input  uart_dbg_pkg::byte_t     mem_wdata_i,
  output uart_dbg_pkg::byte_t     mem_rdata_o
);

  uart_dbg_pkg::byte_t mem_q [`DBG_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (mem_we_i) begin
      mem_q[mem_addr_i] <= mem_wdata_i;
    end
  end

  // Read data follows the address by one cycle
  always_ff @(posedge clk) begin
    mem_rdata_o <= mem_q[mem_addr_i];
  end

endmodule

// ==== rtl/uart_dbg_consts.svh ====
`ifndef UART_DBG_CONSTS_SVH
`define UART_DBG_CONSTS_SVH

// Serial bit time in clock cycles
`define DBG_CLKS_PER_BIT 8

// Command bytes sent by the host
`define DBG_CMD_READ 8'h11
`define DBG_CMD_WRITE 8'h12
`define DBG_CMD_EXEC 8'h13

// Reply bytes sent by the server
`define DBG_ACK 8'h06
`define DBG_EOT 8'h04

// Scratch memory size in bytes
`define DBG_MEM_DEPTH 256

// Bytes in each address, length or entry field on the line
`define DBG_FIELD_BYTES 8

`endif

// ==== rtl/uart_dbg_pkg.sv ====
package uart_dbg_pkg;

  // One byte on the serial line
  typedef logic [7:0] byte_t;

  // Scratch memory address, wraps at 256
  typedef logic [7:0] mem_addr_t;

  // Low part of the 64-bit length field
  typedef logic [15:0] dbg_len_t;

  // Full exec entry address
  typedef logic [63:0] entry_t;

  // Bit timer and bit index in rx and tx, bit times up to 256 clocks
  typedef logic [7:0] bit_cnt_t;

  // Command engine states
  typedef enum logic [2:0] {
    IDLE,
    FIELD,
    SEND_ACK,
    DATA_IN,
    DATA_OUT,
    SEND_EOT,
    EXEC
  } engine_state_e;

endpackage

// ==== rtl/uart_dbg_top.sv ====
`timescale 1ns/1ps

module uart_dbg_top (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 rx_i,
  output logic                 tx_o,
  output logic                 exec_o,
  output uart_dbg_pkg::entry_t entry_o
);

  logic                    rx_valid;
  uart_dbg_pkg::byte_t     rx_data;
  logic                    tx_start;
  uart_dbg_pkg::byte_t     tx_data;
  logic                    tx_busy;
  logic                    mem_we;
  uart_dbg_pkg::mem_addr_t mem_addr;
  uart_dbg_pkg::byte_t     mem_wdata;
  uart_dbg_pkg::byte_t     mem_rdata;

  uart_rx uart_rx_inst (
    .clk        ( clk      ),
    .arst_n_i   ( arst_n_i ),
    .rx_i       ( rx_i     ),
    .rx_valid_o ( rx_valid ),
    .rx_data_o  ( rx_data  )
  );

  dbg_scratch_mem dbg_scratch_mem_inst (
    .clk         ( clk       ),
    .mem_we_i    ( mem_we    ),
    .mem_addr_i  ( mem_addr  ),
    .mem_wdata_i ( mem_wdata ),
    .mem_rdata_o ( mem_rdata )
  );

  dbg_cmd_engine dbg_cmd_engine_inst (
    .clk         ( clk       ),
    .arst_n_i    ( arst_n_i  ),
    .rx_valid_i  ( rx_valid  ),
    .rx_data_i   ( rx_data   ),
    .tx_busy_i   ( tx_busy   ),
    .tx_start_o  ( tx_start  ),
    .tx_data_o   ( tx_data   ),
    .mem_we_o    ( mem_we    ),
    .mem_addr_o  ( mem_addr  ),
    .mem_wdata_o ( mem_wdata ),
    .mem_rdata_i ( mem_rdata ),
    .exec_o      ( exec_o    ),
    .entry_o     ( entry_o   )
  );

  uart_tx uart_tx_inst (
    .clk        ( clk      ),
    .arst_n_i   ( arst_n_i ),
    .tx_start_i ( tx_start ),
    .tx_data_i  ( tx_data  ),
    .tx_busy_o  ( tx_busy  ),
    .tx_o       ( tx_o     )
  );

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps

`include "uart_dbg_consts.svh"

module uart_rx (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                rx_i,
  output logic                rx_valid_o,
  output uart_dbg_pkg::byte_t rx_data_o
);

  localparam uart_dbg_pkg::bit_cnt_t bit_last =
    uart_dbg_pkg::bit_cnt_t'(`DBG_CLKS_PER_BIT - 1);
  localparam uart_dbg_pkg::bit_cnt_t half_last =
    uart_dbg_pkg::bit_cnt_t'(`DBG_CLKS_PER_BIT / 2 - 1);
  // Index 0 is the start bit, 1 to 8 the data bits, 9 the stop bit
  localparam uart_dbg_pkg::bit_cnt_t stop_idx = uart_dbg_pkg::bit_cnt_t'(9);

  logic [1:0]              rx_sync_q;
  logic                    rx_s;
  logic                    active_q;
  uart_dbg_pkg::bit_cnt_t  timer_q;
  uart_dbg_pkg::bit_cnt_t  bit_idx_q;
  uart_dbg_pkg::byte_t     shift_q;
  logic                    sample;

  // Line idles high, so sync flops reset to 1
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_sync_q <= 2'b11;
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
    end
  end

  assign rx_s   = rx_sync_q[1];
  assign sample = active_q && (timer_q == '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q   <= 1'b0;
      timer_q    <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (!active_q) begin
        // Falling edge starts a frame, first sample lands mid start bit
        if (!rx_s) begin
          active_q  <= 1'b1;
          timer_q   <= half_last;
          bit_idx_q <= '0;
        end
      end else if (!sample) begin
        timer_q <= timer_q - 1'b1;
      end else begin
        timer_q <= bit_last;
        if (bit_idx_q == '0) begin
          // Glitch, not a real start bit
          if (rx_s) begin
            active_q <= 1'b0;
          end else begin
            bit_idx_q <= bit_idx_q + 1'b1;
          end
        end else if (bit_idx_q == stop_idx) begin
          active_q   <= 1'b0;
          rx_valid_o <= rx_s;
        end else begin
          bit_idx_q <= bit_idx_q + 1'b1;
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_idx_q != '0 && bit_idx_q != stop_idx) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
    if (sample && bit_idx_q == stop_idx) begin
      rx_data_o <= shift_q;
    end
  end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

`include "uart_dbg_consts.svh"

module uart_tx (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                tx_start_i,
  input  uart_dbg_pkg::byte_t tx_data_i,
  output logic                tx_busy_o,
  output logic                tx_o
);

  localparam uart_dbg_pkg::bit_cnt_t bit_last =
    uart_dbg_pkg::bit_cnt_t'(`DBG_CLKS_PER_BIT - 1);
  // Start, 8 data bits, stop
  localparam uart_dbg_pkg::bit_cnt_t frame_last = uart_dbg_pkg::bit_cnt_t'(9);

  logic [9:0]             frame_q;
  uart_dbg_pkg::bit_cnt_t timer_q;
  uart_dbg_pkg::bit_cnt_t bit_idx_q;
  logic                   accept;
  logic                   bit_end;

  assign accept  = tx_start_i && !tx_busy_o;
  assign bit_end = tx_busy_o && (timer_q == '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_busy_o <= 1'b0;
      tx_o      <= 1'b1;
      timer_q   <= '0;
      bit_idx_q <= '0;
    end else if (accept) begin
      tx_busy_o <= 1'b1;
      tx_o      <= 1'b0;
      timer_q   <= bit_last;
      bit_idx_q <= '0;
    end else if (tx_busy_o && !bit_end) begin
      timer_q <= timer_q - 1'b1;
    end else if (bit_end) begin
      timer_q <= bit_last;
      if (bit_idx_q == frame_last) begin
        tx_busy_o <= 1'b0;
        tx_o      <= 1'b1;
      end else begin
        bit_idx_q <= bit_idx_q + 1'b1;
        // Next bit sits one above the one on the line
        tx_o      <= frame_q[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      frame_q <= {1'b1, tx_data_i, 1'b0};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/uart_dbg_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/dbg_scratch_mem.sv
rtl/dbg_cmd_engine.sv
rtl/uart_dbg_top.sv
tests/uart_dbg_checker.sv
tests/tb_uart_dbg.sv

// ==== tests/tb_uart_dbg.sv ====
`timescale 1ns/1ps

`include "uart_dbg_consts.svh"

module tb_uart_dbg;

  localparam int clk_period   = 100;
  localparam int frame_cycles = 10 * `DBG_CLKS_PER_BIT;
  localparam int max_len      = 16;
  // Command, two fields, longest payload and replies, with margin
  localparam int row_cycles   = (2 * `DBG_FIELD_BYTES + max_len + 8) * frame_cycles;
  localparam int num_rows     = 11;

  typedef enum logic [2:0] {OP_ACK, OP_WRITE, OP_READ, OP_EXEC, OP_BAD} op_e;

  // For OP_BAD the seed column holds the stray command byte
  typedef struct packed {
    op_e                  kind;
    logic [63:0]          addr;
    logic [63:0]          len;
    logic [7:0]           seed;
    uart_dbg_pkg::entry_t entry;
  } row_t;

  logic                 clk;
  logic                 arst_n_i;
  logic                 rx_i;
  logic                 tx_o;
  logic                 exec_o;
  uart_dbg_pkg::entry_t entry_o;

  row_t                stim_rows [num_rows];
  uart_dbg_pkg::byte_t model_mem [`DBG_MEM_DEPTH];
  int                  miss_cnt = 0;
  int                  total;

  uart_dbg_top uart_dbg_top_inst (
    .clk      ( clk      ),
    .arst_n_i ( arst_n_i ),
    .rx_i     ( rx_i     ),
    .tx_o     ( tx_o     ),
    .exec_o   ( exec_o   ),
    .entry_o  ( entry_o  )
  );

  uart_dbg_checker uart_dbg_checker_inst (
    .clk      ( clk      ),
    .arst_n_i ( arst_n_i ),
    .tx_i     ( tx_o     ),
    .exec_i   ( exec_o   ),
    .entry_i  ( entry_o  )
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // One 8N1 frame, each bit held for a full bit time
  task automatic send_byte(input uart_dbg_pkg::byte_t b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      rx_i  = frame[0];
      frame = frame >> 1;
      repeat (`DBG_CLKS_PER_BIT - 1) @(negedge clk);
    end
  endtask

  // Fields go out LSB first
  task automatic send_field(input logic [63:0] value);
    logic [63:0] v;
    int          i;
    v = value;
    for (i = 0; i < `DBG_FIELD_BYTES; i++) begin
      send_byte(v[7:0]);
      v = v >> 8;
    end
  endtask

  task automatic wait_replies();
    int n;
    n = 0;
    while ((uart_dbg_checker_inst.exp_q.size() != 0 ||
            uart_dbg_checker_inst.exp_entry_q.size() != 0) && n < row_cycles) begin
      @(negedge clk);
      n++;
    end
    if (uart_dbg_checker_inst.exp_q.size() != 0 ||
        uart_dbg_checker_inst.exp_entry_q.size() != 0) begin
      $display("reply missing: %0d bytes and %0d exec pulses never seen",
               uart_dbg_checker_inst.exp_q.size(),
               uart_dbg_checker_inst.exp_entry_q.size());
      miss_cnt++;
      uart_dbg_checker_inst.exp_q.delete();
      uart_dbg_checker_inst.exp_entry_q.delete();
    end
  endtask

  task automatic run_row(input row_t r);
    int                      base;
    int                      n;
    int                      i;
    uart_dbg_pkg::mem_addr_t idx;
    uart_dbg_pkg::byte_t     b;
    // Only the low address byte and low length half-word count
    base = int'(r.addr[7:0]);
    n    = int'(r.len[15:0]);
    case (r.kind)
      OP_ACK: begin
        uart_dbg_checker_inst.exp_q.push_back(`DBG_ACK);
        send_byte(`DBG_ACK);
        wait_replies();
      end
      OP_WRITE: begin
        uart_dbg_checker_inst.exp_q.push_back(`DBG_ACK);
        if (n == 0) begin
          uart_dbg_checker_inst.exp_q.push_back(`DBG_EOT);
        end
        send_byte(`DBG_CMD_WRITE);
        send_field(r.addr);
        send_field(r.len);
        wait_replies();
        if (n != 0) begin
          uart_dbg_checker_inst.exp_q.push_back(`DBG_EOT);
          for (i = 0; i < n; i++) begin
            b   = uart_dbg_pkg::byte_t'($urandom) ^ r.seed;
            idx = uart_dbg_pkg::mem_addr_t'((base + i) % `DBG_MEM_DEPTH);
            model_mem[idx] = b;
            send_byte(b);
          end
          wait_replies();
        end
      end
      OP_READ: begin
        uart_dbg_checker_inst.exp_q.push_back(`DBG_ACK);
        for (i = 0; i < n; i++) begin
          idx = uart_dbg_pkg::mem_addr_t'((base + i) % `DBG_MEM_DEPTH);
          uart_dbg_checker_inst.exp_q.push_back(model_mem[idx]);
        end
        uart_dbg_checker_inst.exp_q.push_back(`DBG_EOT);
        send_byte(`DBG_CMD_READ);
        send_field(r.addr);
        send_field(r.len);
        wait_replies();
      end
      OP_EXEC: begin
        uart_dbg_checker_inst.exp_entry_q.push_back(r.entry);
        uart_dbg_checker_inst.exp_q.push_back(`DBG_ACK);
        send_byte(`DBG_CMD_EXEC);
        send_field(r.entry);
        wait_replies();
      end
      default: begin
        // No reply expected, the checker flags anything on the line
        send_byte(r.seed);
        repeat (3 * frame_cycles) @(negedge clk);
      end
    endcase
  endtask

  initial begin
    int row_idx;
    void'($urandom(32'h4cbf));
    rx_i     = 1'b1;
    arst_n_i = 1'b0;
    stim_rows[0]  = '{OP_ACK,   64'h0, 64'h0, 8'h00, 64'h0};
    stim_rows[1]  = '{OP_WRITE, 64'hffff_0000_0000_0010, 64'h0000_0001_0000_0010, 8'h00, 64'h0};
    stim_rows[2]  = '{OP_READ,  64'h10, 64'd16, 8'h00, 64'h0};
    stim_rows[3]  = '{OP_WRITE, 64'hf8, 64'd12, 8'h5a, 64'h0};
    stim_rows[4]  = '{OP_READ,  64'h1234_0000_0000_00f8, 64'd12, 8'h00, 64'h0};
    stim_rows[5]  = '{OP_BAD,   64'h0, 64'h0, 8'h55, 64'h0};
    stim_rows[6]  = '{OP_READ,  64'h14, 64'd6, 8'h00, 64'h0};
    stim_rows[7]  = '{OP_EXEC,  64'h0, 64'h0, 8'h00, 64'h8000_0000_1000_0080};
    stim_rows[8]  = '{OP_WRITE, 64'h40, 64'habcd_0000_0001_0000, 8'h00, 64'h0};
    stim_rows[9]  = '{OP_EXEC,  64'h0, 64'h0, 8'h00, 64'h0123_4567_89ab_cdef};
    stim_rows[10] = '{OP_ACK,   64'h0, 64'h0, 8'h00, 64'h0};
    repeat (5) @(negedge clk);
    arst_n_i = 1'b1;
    // Quiet line before the first command
    repeat (2 * frame_cycles) @(negedge clk);
    for (row_idx = 0; row_idx < num_rows; row_idx++) begin
      run_row(stim_rows[row_idx]);
    end
    repeat (3 * frame_cycles) @(negedge clk);
    total = uart_dbg_checker_inst.tx_err_cnt + uart_dbg_checker_inst.exec_err_cnt + miss_cnt;
    $display("errors: tx %0d, exec %0d, missing %0d", uart_dbg_checker_inst.tx_err_cnt,
             uart_dbg_checker_inst.exec_err_cnt, miss_cnt);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (num_rows * row_cycles + 10 * frame_cycles) @(posedge clk);
    $display("watchdog expired, run stopped before all rows finished");
    $display("errors: tx %0d, exec %0d, missing %0d", uart_dbg_checker_inst.tx_err_cnt,
             uart_dbg_checker_inst.exec_err_cnt, miss_cnt);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== tests/uart_dbg_checker.sv ====
`timescale 1ns/1ps

`include "uart_dbg_consts.svh"

module uart_dbg_checker (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 tx_i,
  input  logic                 exec_i,
  input  uart_dbg_pkg::entry_t entry_i
);

  // Expected replies filled by the testbench model
  uart_dbg_pkg::byte_t  exp_q [$];
  uart_dbg_pkg::entry_t exp_entry_q [$];

  int tx_err_cnt   = 0;
  int exec_err_cnt = 0;

  uart_dbg_pkg::byte_t  got_byte;
  uart_dbg_pkg::byte_t  exp_byte;
  uart_dbg_pkg::entry_t exp_entry;
  uart_dbg_pkg::entry_t held_entry;
  int                   bit_num;

  // Decode the transmit line by sampling mid-bit on falling edges
  initial begin
    forever begin
      @(negedge clk);
      if (arst_n_i && !tx_i) begin
        repeat (`DBG_CLKS_PER_BIT / 2) @(negedge clk);
        if (tx_i) begin
          $display("short low pulse on tx line, no valid start bit");
          tx_err_cnt++;
        end else begin
          for (bit_num = 0; bit_num < 8; bit_num++) begin
            repeat (`DBG_CLKS_PER_BIT) @(negedge clk);
            got_byte = {tx_i, got_byte[7:1]};
          end
          repeat (`DBG_CLKS_PER_BIT) @(negedge clk);
          if (!tx_i) begin
            $display("framing error, stop bit low on tx line");
            tx_err_cnt++;
          end
          if (exp_q.size() == 0) begin
            $display("unexpected byte %h on tx line", got_byte);
            tx_err_cnt++;
          end else begin
            exp_byte = exp_q.pop_front();
            if (got_byte !== exp_byte) begin
              $display("mismatch tx_byte got %h exp %h", got_byte, exp_byte);
              tx_err_cnt++;
            end
          end
        end
      end
    end
  end

  // Exec pulses and the held entry value
  initial begin
    held_entry = '0;
    forever begin
      @(negedge clk);
      if (!arst_n_i) begin
        held_entry = '0;
      end else if (exec_i) begin
        if (exp_entry_q.size() == 0) begin
          $display("unexpected exec pulse with entry %h", entry_i);
          exec_err_cnt++;
          held_entry = entry_i;
        end else begin
          exp_entry = exp_entry_q.pop_front();
          if (entry_i !== exp_entry) begin
            $display("mismatch entry_o got %h exp %h", entry_i, exp_entry);
            exec_err_cnt++;
          end
          held_entry = exp_entry;
        end
      end else if (entry_i !== held_entry) begin
        // Entry must hold between pulses
        $display("mismatch entry_o got %h exp %h", entry_i, held_entry);
        exec_err_cnt++;
        held_entry = entry_i;
      end
    end
  end

endmodule
